/* all.f */
+incdir+.
wb_iob_pkg.sv
wb_iob_bridge.sv
iob_addr_decode.sv
iob_sram.sv
iob_reg_bank.sv
wb_iob_top.sv
wb_iob_checker.sv
wb_iob_tb.sv

/* iob_addr_decode.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module iob_addr_decode (
   // from the bridge
   input  wb_iob_pkg::iob_req_t iob_req_i,
   output wb_iob_pkg::iob_rsp_t iob_rsp_o,
   // sram target
   output wb_iob_pkg::iob_req_t sram_req_o,
   input  wb_iob_pkg::iob_rsp_t sram_rsp_i,
   // register bank target
   output wb_iob_pkg::iob_req_t reg_req_o,
   input  wb_iob_pkg::iob_rsp_t reg_rsp_i
);

   logic reg_sel;

   assign reg_sel = iob_req_i.address[`REG_SEL_BIT];

   // ==========================================================
   // request steering
   // ==========================================================
   always_comb begin
      sram_req_o        = iob_req_i;
      reg_req_o         = iob_req_i;
      sram_req_o.avalid = iob_req_i.avalid & ~reg_sel;
      reg_req_o.avalid  = iob_req_i.avalid & reg_sel;
   end

   // ==========================================================
   // response merge
   // ==========================================================
   // ready follows the addressed target
   assign iob_rsp_o.ready = reg_sel ? reg_rsp_i.ready : sram_rsp_i.ready;

   // read data is one cycle late, so pick by rvalid not by address
   assign iob_rsp_o.rvalid = sram_rsp_i.rvalid | reg_rsp_i.rvalid;
   assign iob_rsp_o.rdata  = reg_rsp_i.rvalid ? reg_rsp_i.rdata : sram_rsp_i.rdata;

   // only one request is in flight, so only one target may answer
   rvalid_onehot_a : assert final (
      !((sram_rsp_i.rvalid === 1'b1) && (reg_rsp_i.rvalid === 1'b1))
   );

endmodule

/* iob_reg_bank.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module iob_reg_bank (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  wb_iob_pkg::iob_req_t req_i,
   output wb_iob_pkg::iob_rsp_t rsp_o
);

   // register index, byte address bits 3:2
   localparam logic [1:0] REG_IDENT   = 2'd0;
   localparam logic [1:0] REG_SCRATCH = 2'd1;
   localparam logic [1:0] REG_MASK    = 2'd2;
   localparam logic [1:0] REG_STATUS  = 2'd3;

   logic [             1:0] reg_idx;
   logic                    wr_en;
   logic                    rd_en;
   logic [`WB_DATA_W-1:0] scratch_q;
   logic [`WB_DATA_W-1:0] mask_q;
   logic [`WB_DATA_W-1:0] rd_mux;
   logic [`WB_DATA_W-1:0] rdata_q;
   logic                    rvalid_q;

   assign reg_idx = req_i.address[3:2];
   assign wr_en   = req_i.avalid & (|req_i.wstrb);
   assign rd_en   = req_i.avalid & ~(|req_i.wstrb);

   // ==========================================================
   // writable registers
   // ==========================================================
   // identity and status ignore writes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         scratch_q <= '0;
         mask_q    <= '0;
      end else begin
         for (int b = 0; b < `WB_SEL_W; b++) begin
            if (wr_en && req_i.wstrb[b]) begin
               if (reg_idx == REG_SCRATCH) begin
                  scratch_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
               if (reg_idx == REG_MASK) begin
                  mask_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end
      end
   end

   // ==========================================================
   // read path
   // ==========================================================
   always_comb begin
      case (reg_idx)
         REG_IDENT:   rd_mux = `REG_ID_VAL;
         REG_SCRATCH: rd_mux = scratch_q;
         REG_MASK:    rd_mux = mask_q;
         REG_STATUS:  rd_mux = scratch_q & mask_q;
         default:     rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rd_mux;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   assign rsp_o.rdata  = rdata_q;
   assign rsp_o.rvalid = rvalid_q;
   assign rsp_o.ready  = 1'b1;

endmodule

/* iob_sram.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module iob_sram (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  wb_iob_pkg::iob_req_t req_i,
   output wb_iob_pkg::iob_rsp_t rsp_o
);

   logic [`WB_DATA_W-1:0] mem [0:(2**`SRAM_AW)-1];
   logic [  `SRAM_AW-1:0] word_addr;
   logic                  rd_en;
   logic [`WB_DATA_W-1:0] rdata_q;
   logic                  rvalid_q;

   // byte address to word index
   assign word_addr = req_i.address[`SRAM_AW+1:2];

   // always ready, so avalid alone means accepted
   assign rd_en = req_i.avalid & ~(|req_i.wstrb);

   // ==========================================================
   // storage
   // ==========================================================
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < `WB_SEL_W; b++) begin
         if (req_i.avalid && req_i.wstrb[b]) begin
            mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
         end
      end
      if (rd_en) begin
         rdata_q <= mem[word_addr];
      end
   end

   // one-cycle read pulse
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   assign rsp_o.rdata  = rdata_q;
   assign rsp_o.rvalid = rvalid_q;
   assign rsp_o.ready  = 1'b1;

endmodule

/* wb_iob_bridge.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module wb_iob_bridge (
   input  logic                clk_i,
   input  logic                rst_i,
   // wishbone slave side
   input  wb_iob_pkg::wb_req_t wb_req_i,
   output wb_iob_pkg::wb_rsp_t wb_rsp_o,
   // iob master side
   output wb_iob_pkg::iob_req_t iob_req_o,
   input  wb_iob_pkg::iob_rsp_t iob_rsp_i
);

   logic                  avalid;
   logic [ `WB_SEL_W-1:0] wstrb;
   logic                  wack;
   logic                  wack_q;
   logic                  ack;
   logic [`WB_DATA_W-1:0] data_mask;

   // ==========================================================
   // request side
   // ==========================================================
   // drop the request once acked so a held stb is not taken twice
   assign avalid = wb_req_i.cyc & wb_req_i.stb & ~ack;

   // reads carry no strobes
   assign wstrb = wb_req_i.we ? wb_req_i.sel : '0;

   assign iob_req_o.avalid  = avalid;
   assign iob_req_o.address = wb_req_i.addr;
   assign iob_req_o.wdata   = wb_req_i.data;
   assign iob_req_o.wstrb   = wstrb;

   // ==========================================================
   // acknowledge
   // ==========================================================
   // write accepted this cycle
   assign wack = iob_rsp_i.ready & avalid & (|wstrb);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wack_q <= 1'b0;
      end else begin
         wack_q <= wack;
      end
   end

   // reads ack on rvalid, writes one cycle after acceptance
   assign ack = wack_q | iob_rsp_i.rvalid;

   // ==========================================================
   // read data
   // ==========================================================
   always_comb begin
      for (int b = 0; b < `WB_SEL_W; b++) begin
         data_mask[8*b +: 8] = {8{wb_req_i.sel[b]}};
      end
   end

   assign wb_rsp_o.ack  = ack;
   assign wb_rsp_o.data = iob_rsp_i.rdata & data_mask;

   // ==========================================================
   // checks
   // ==========================================================
   // master must still own the bus when the ack comes back
   ack_needs_cyc_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      ack |-> wb_req_i.cyc
   );

   // a target answers only while the master is strobing
   rvalid_needs_stb_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      iob_rsp_i.rvalid |-> wb_req_i.stb
   );

endmodule

/* wb_iob_checker.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module wb_iob_checker (
   input  logic                clk_i,
   input  logic                rst_i,
   input  wb_iob_pkg::wb_req_t wb_req_i,
   input  wb_iob_pkg::wb_rsp_t wb_rsp_i,
   input  logic [3:0]          test_num_i,
   input  logic                test_done_i,
   output int                  err_cnt_o,
   output int                  chk_cnt_o
);

   localparam int SRAM_BYTES = 4 * (2 ** `SRAM_AW);

   // reference model, one valid bit per sram byte
   logic [7:0]  sram_m [0:SRAM_BYTES-1];
   bit          byte_ok [0:SRAM_BYTES-1];
   logic [31:0] scratch_m;
   logic [31:0] mask_m;
   logic        req_on;
   int          stb_cycles;
   int          err_cnt;
   int          chk_cnt;
   int          err_base;
   int          chk_base;

   assign req_on    = wb_req_i.cyc & wb_req_i.stb;
   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

   function automatic string test_name(input logic [3:0] n);
      case (n)
         4'd1:    return "ident_reg";
         4'd2:    return "reg_bytes";
         4'd3:    return "sram_rw";
         4'd4:    return "partial_sel";
         4'd5:    return "ack_timing";
         4'd6:    return "random_mix";
         default: return "idle";
      endcase
   endfunction

   // ==========================================================
   // model update and read compare
   // ==========================================================
   task automatic apply_write(input logic [31:0] addr, input logic [3:0] sel,
                              input logic [31:0] data);
      int idx;
      for (int b = 0; b < `WB_SEL_W; b++) begin
         idx = addr[`SRAM_AW+1:2] * 4 + b;
         if (sel[b] && addr[`REG_SEL_BIT]) begin
            if (addr[3:2] == 2'd1) scratch_m[8*b +: 8] = data[8*b +: 8];
            if (addr[3:2] == 2'd2) mask_m[8*b +: 8] = data[8*b +: 8];
         end else if (sel[b]) begin
            sram_m[idx]  = data[8*b +: 8];
            byte_ok[idx] = 1'b1;
         end
      end
   endtask

   task automatic check_read(input logic [31:0] addr, input logic [3:0] sel,
                             input logic [31:0] act);
      logic [31:0] reg_word;
      logic [31:0] exp_data;
      logic [31:0] lanes;
      int          idx;
      case (addr[3:2])
         2'd0:    reg_word = `REG_ID_VAL;
         2'd1:    reg_word = scratch_m;
         2'd2:    reg_word = mask_m;
         default: reg_word = scratch_m & mask_m;
      endcase
      exp_data = '0;
      lanes    = '0;
      for (int b = 0; b < `WB_SEL_W; b++) begin
         idx = addr[`SRAM_AW+1:2] * 4 + b;
         // unselected lanes must read as zero
         if (!sel[b] || addr[`REG_SEL_BIT] || byte_ok[idx]) lanes[8*b +: 8] = 8'hff;
         if (sel[b] && addr[`REG_SEL_BIT]) exp_data[8*b +: 8] = reg_word[8*b +: 8];
         else if (sel[b] && byte_ok[idx]) exp_data[8*b +: 8] = sram_m[idx];
      end
      chk_cnt++;
      if ((act & lanes) !== exp_data) begin
         err_cnt++;
         $display("[ERROR] %s: expected %h, actual %h (addr %h sel %b)",
                  test_name(test_num_i), exp_data, act & lanes, addr, sel);
      end
   endtask

   // ==========================================================
   // bus monitor, sampled mid-cycle
   // ==========================================================
   always @(negedge clk_i) begin
      if (rst_i) begin
         stb_cycles = 0;
         scratch_m  = '0;
         mask_m     = '0;
      end else begin
         if (wb_rsp_i.ack) begin
            chk_cnt++;
            if (!req_on) begin
               err_cnt++;
               $display("%s: ack went high with no request pending", test_name(test_num_i));
            end else if (stb_cycles != 1) begin
               err_cnt++;
               $display("%s: ack came %0d cycles after stb rose instead of 1",
                        test_name(test_num_i), stb_cycles);
            end else if (wb_req_i.we) begin
               apply_write(wb_req_i.addr, wb_req_i.sel, wb_req_i.data);
            end else begin
               check_read(wb_req_i.addr, wb_req_i.sel, wb_rsp_i.data);
            end
         end else if (req_on && stb_cycles == 1) begin
            err_cnt++;
            $display("%s: no ack one cycle after stb rose", test_name(test_num_i));
         end
         stb_cycles = req_on ? stb_cycles + 1 : 0;
         if (test_done_i) begin
            $display("test %0d %s finished: %0d checks, %0d errors", test_num_i,
                     test_name(test_num_i), chk_cnt - chk_base, err_cnt - err_base);
            chk_base = chk_cnt;
            err_base = err_cnt;
         end
      end
   end

endmodule

/* wb_iob_params.svh */
`ifndef WB_IOB_PARAMS_SVH
`define WB_IOB_PARAMS_SVH

// ==========================================================
// bus widths
// ==========================================================
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W (`WB_DATA_W / 8)

// ==========================================================
// memory map
// ==========================================================
// sram word address, 1024 words
`define SRAM_AW 10
// byte address bit, high selects the register bank
`define REG_SEL_BIT 12

// read-only identity register
`define REG_ID_VAL 32'h0b1d_0001

`endif

/* wb_iob_pkg.sv */
`include "wb_iob_params.svh"

package wb_iob_pkg;

   // ==========================================================
   // wishbone classic
   // ==========================================================
   typedef struct packed {
      logic [`WB_ADDR_W-1:0] addr;
      logic [ `WB_SEL_W-1:0] sel;
      logic                  we;
      logic                  cyc;
      logic                  stb;
      logic [`WB_DATA_W-1:0] data;
   } wb_req_t;

   typedef struct packed {
      logic                  ack;
      logic [`WB_DATA_W-1:0] data;
   } wb_rsp_t;

   // ==========================================================
   // iob native
   // ==========================================================
   // wstrb of zero means a read
   typedef struct packed {
      logic                  avalid;
      logic [`WB_ADDR_W-1:0] address;
      logic [`WB_DATA_W-1:0] wdata;
      logic [ `WB_SEL_W-1:0] wstrb;
   } iob_req_t;

   typedef struct packed {
      logic [`WB_DATA_W-1:0] rdata;
      logic                  rvalid;
      logic                  ready;
   } iob_rsp_t;

endpackage

/* wb_iob_tb.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module wb_iob_tb;

   localparam int  CLK_NS    = 4;
   localparam real DRIVE_DLY = 0.5;
   localparam int  N_SRAM    = 32;
   localparam int  N_MIX     = 200;
   // transactions per test 1 to 6
   localparam int  TOTAL_TXN = 3 + 20 + (2 * N_SRAM + 2) + 14 + 8 + N_MIX;
   localparam int  TIMEOUT_NS = TOTAL_TXN * 3 * CLK_NS + 100 * CLK_NS;

   logic                clk_i = 1'b0;
   logic                rst_i;
   wb_iob_pkg::wb_req_t wb_req;
   wb_iob_pkg::wb_rsp_t wb_rsp;
   logic [3:0]          test_num;
   logic                test_done;
   int                  err_cnt;
   int                  chk_cnt;
   integer              seed;
   logic [31:0]         addrs [0:N_SRAM-1];
   logic [3:0]          part_sel [0:7] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha};

   always #(CLK_NS / 2) clk_i = ~clk_i;

   wb_iob_top wb_iob_top_i (.clk_i(clk_i), .rst_i(rst_i), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp));

   wb_iob_checker wb_iob_checker_i (
      .clk_i(clk_i), .rst_i(rst_i), .wb_req_i(wb_req), .wb_rsp_i(wb_rsp),
      .test_num_i(test_num), .test_done_i(test_done),
      .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
   );

   // ==========================================================
   // wishbone master, called just after a rising edge
   // ==========================================================
   task automatic bus_cycle(input logic [31:0] addr, input logic we, input logic [3:0] sel,
                            input logic [31:0] data);
      wb_req = '{addr: addr, sel: sel, we: we, cyc: 1'b1, stb: 1'b1, data: data};
      @(negedge clk_i);
      while (!wb_rsp.ack) @(negedge clk_i);
      @(posedge clk_i);
      #DRIVE_DLY;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      @(posedge clk_i);
      #DRIVE_DLY;
   endtask

   task automatic write_word(input logic [31:0] addr, input logic [3:0] sel,
                             input logic [31:0] data);
      bus_cycle(addr, 1'b1, sel, data);
   endtask

   task automatic read_word(input logic [31:0] addr, input logic [3:0] sel);
      bus_cycle(addr, 1'b0, sel, $random(seed));
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
      #DRIVE_DLY;
   endtask

   task automatic end_test();
      test_done = 1'b1;
      idle_cycles(1);
      test_done = 1'b0;
      test_num  = test_num + 1'b1;
   endtask

   // write strobes never all zero
   function automatic logic [3:0] rand_sel();
      logic [3:0] s;
      s = $random(seed);
      return (s == 4'h0) ? 4'hf : s;
   endfunction

   // upper address bits are random on purpose
   function automatic logic [31:0] sram_addr();
      logic [31:0] a;
      a = $random(seed);
      a[`REG_SEL_BIT] = 1'b0;
      a[1:0] = 2'b00;
      return a;
   endfunction

   function automatic logic [31:0] reg_addr(input logic [1:0] idx);
      logic [31:0] a;
      a = $random(seed);
      a[`REG_SEL_BIT] = 1'b1;
      a[3:0] = {idx, 2'b00};
      return a;
   endfunction

   // ==========================================================
   // test sequence
   // ==========================================================
   initial begin
      seed = 32'h52e8_119e;
      rst_i = 1'b1;
      wb_req = '0;
      test_num = 4'd1;
      test_done = 1'b0;
      repeat (3) @(posedge clk_i);
      #DRIVE_DLY;
      rst_i = 1'b0;
      idle_cycles(5);
      read_word(reg_addr(2'd0), 4'hf);
      write_word(reg_addr(2'd0), 4'hf, 32'hffff_ffff);
      read_word(reg_addr(2'd0), 4'hf);
      end_test();
      for (int i = 0; i < 4; i++) begin
         write_word(reg_addr(2'd1), rand_sel(), $random(seed));
         write_word(reg_addr(2'd2), rand_sel(), $random(seed));
         for (int r = 1; r < 4; r++) read_word(reg_addr(r[1:0]), 4'hf);
      end
      end_test();
      for (int i = 0; i < N_SRAM; i++) begin
         addrs[i] = sram_addr();
         write_word(addrs[i], rand_sel(), $random(seed));
      end
      for (int i = 0; i < N_SRAM; i++) read_word(addrs[i], 4'hf);
      read_word(reg_addr(2'd1), 4'hf);
      read_word(reg_addr(2'd2), 4'hf);
      end_test();
      write_word(32'h0000_0040, 4'hf, $random(seed));
      write_word(reg_addr(2'd1), 4'hf, $random(seed));
      for (int i = 0; i < 8; i++) read_word(32'h0000_0040, part_sel[i]);
      for (int i = 0; i < 4; i++) read_word(reg_addr(2'd1), rand_sel());
      end_test();
      write_word(32'h0000_0080, 4'hf, $random(seed));
      read_word(32'h0000_0080, 4'hf);
      write_word(reg_addr(2'd1), 4'hf, $random(seed));
      read_word(reg_addr(2'd1), 4'hf);
      read_word(reg_addr(2'd0), 4'hf);
      write_word(reg_addr(2'd2), 4'hf, $random(seed));
      read_word(reg_addr(2'd2), 4'hf);
      read_word(reg_addr(2'd3), 4'hf);
      end_test();
      // narrow window so reads often hit written words
      for (int i = 0; i < N_MIX; i++) begin
         logic [31:0] a;
         a = $random(seed);
         a[11:8] = 4'h0;
         a[1:0] = 2'b00;
         bus_cycle(a, $random(seed), rand_sel(), $random(seed));
      end
      end_test();
      idle_cycles(2);
      $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* wb_iob_top.sv */
`timescale 1ns/1ps

`include "wb_iob_params.svh"

module wb_iob_top (
   input  logic                clk_i,
   input  logic                rst_i,
   input  wb_iob_pkg::wb_req_t wb_req_i,
   output wb_iob_pkg::wb_rsp_t wb_rsp_o
);

   wb_iob_pkg::iob_req_t iob_req;
   wb_iob_pkg::iob_rsp_t iob_rsp;
   wb_iob_pkg::iob_req_t sram_req;
   wb_iob_pkg::iob_rsp_t sram_rsp;
   wb_iob_pkg::iob_req_t reg_req;
   wb_iob_pkg::iob_rsp_t reg_rsp;

   // ==========================================================
   // wishbone to iob
   // ==========================================================
   wb_iob_bridge wb_iob_bridge_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (wb_req_i),
      .wb_rsp_o (wb_rsp_o),
      .iob_req_o(iob_req),
      .iob_rsp_i(iob_rsp)
   );

   iob_addr_decode iob_addr_decode_i (
      .iob_req_i (iob_req),
      .iob_rsp_o (iob_rsp),
      .sram_req_o(sram_req),
      .sram_rsp_i(sram_rsp),
      .reg_req_o (reg_req),
      .reg_rsp_i (reg_rsp)
   );

   // ==========================================================
   // targets
   // ==========================================================
   iob_sram iob_sram_i (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .req_i(sram_req),
      .rsp_o(sram_rsp)
   );

   iob_reg_bank iob_reg_bank_i (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .req_i(reg_req),
      .rsp_o(reg_rsp)
   );

   // zero wait states end to end
   stb_to_ack_a : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (wb_req_i.cyc && $rose(wb_req_i.stb)) |=> wb_rsp_o.ack
   );

endmodule
